/* logic/task_map_pkg.sv */
// ####################
// Task mapper package
// Grid constants, coordinate and id types, PE id helper
// ####################

package task_map_pkg;

  // Grid geometry
  localparam int grid_dim = 4;
  localparam int id_row_stride = 8;

  typedef logic [1:0] coord_t;
  typedef logic [4:0] pe_id_t;
  typedef logic [2:0] dist_t;
  typedef logic [3:0] count_t;

  // Master controller tile, never allocated
  localparam coord_t ctrl_row = 2'd3;
  localparam coord_t ctrl_col = 2'd3;

  // Largest distance that still counts as a neighbour
  localparam int opt_dist = 2;

  // PE numbering is row times stride plus column
  function automatic pe_id_t pe_id(input coord_t row, input coord_t col);
    return pe_id_t'(row * id_row_stride + col);
  endfunction

endpackage

/* logic/task_req_if.sv */
// ####################
// Request bus
// Captured task request from input side to selector
// ####################

`timescale 1ns/1ps

interface task_req_if;

  logic                 valid;
  logic                 root;
  task_map_pkg::coord_t row;
  task_map_pkg::coord_t col;
  logic                 app_end;

  modport src (
    output valid, root, row, col, app_end
  );

  modport dst (
    input valid, root, row, col, app_end
  );

endinterface

/* logic/map_result_if.sv */
// ####################
// Placement bus
// Chosen PE and request fields from selector to output side
// ####################

`timescale 1ns/1ps

interface map_result_if;

  // One of valid or busy per request
  logic                 valid;
  logic                 busy;
  // Chosen PE position
  task_map_pkg::coord_t x;
  task_map_pkg::coord_t y;
  // Request fields carried along
  logic                 root;
  task_map_pkg::coord_t row;
  task_map_pkg::coord_t col;
  logic                 app_end;

  modport src (
    output valid, busy, x, y, root, row, col, app_end
  );

  modport dst (
    input valid, busy, x, y, root, row, col, app_end
  );

endinterface

/* logic/task_req_capture.sv */
// ####################
// Request capture
// Registers the top-level request strobe and its fields
// ####################

`timescale 1ns/1ps

module task_req_capture (
  input  logic                 clk,
  input  logic                 rst_b,
  input  logic                 task_req,
  input  logic                 root,
  input  task_map_pkg::coord_t row,
  input  task_map_pkg::coord_t col,
  input  logic                 app_end,
  task_req_if.src              req
);

  // Strobes
  always_ff @(posedge clk) begin
    if (!rst_b) begin
      req.valid   <= 1'b0;
      req.app_end <= 1'b0;
    end else begin
      req.valid   <= task_req;
      req.app_end <= app_end;
    end
  end

  // Fields only load with a request
  always_ff @(posedge clk) begin
    if (task_req) begin
      req.root <= root;
      req.row  <= row;
      req.col  <= col;
    end
  end

endmodule

/* logic/pe_occupancy.sv */
// ####################
// PE occupancy
// Busy map of the cluster with a release countdown per PE
// ####################

`timescale 1ns/1ps

module pe_occupancy #(
  parameter int hold_cycles = 20
) (
  input  logic                 clk,
  input  logic                 rst_b,
  input  logic                 alloc,
  input  task_map_pkg::coord_t alloc_x,
  input  task_map_pkg::coord_t alloc_y,
  output logic [task_map_pkg::grid_dim-1:0][task_map_pkg::grid_dim-1:0] busy_map
);

  localparam int cnt_w = $clog2(hold_cycles + 1);

  logic [cnt_w-1:0] cnt [task_map_pkg::grid_dim][task_map_pkg::grid_dim];

  // ####################
  // Countdowns
  // ####################

  // Allocation reloads, otherwise count down to zero
  always_ff @(posedge clk) begin
    if (!rst_b) begin
      for (int r = 0; r < task_map_pkg::grid_dim; r++) begin
        for (int c = 0; c < task_map_pkg::grid_dim; c++) begin
          cnt[r][c] <= '0;
        end
      end
    end else begin
      for (int r = 0; r < task_map_pkg::grid_dim; r++) begin
        for (int c = 0; c < task_map_pkg::grid_dim; c++) begin
          if (alloc && alloc_x == task_map_pkg::coord_t'(r) &&
              alloc_y == task_map_pkg::coord_t'(c)) begin
            cnt[r][c] <= cnt_w'(hold_cycles);
          end else if (cnt[r][c] != '0) begin
            cnt[r][c] <= cnt[r][c] - 1'b1;
          end
        end
      end
    end
  end

  // Busy while the countdown is running
  always_comb begin
    for (int r = 0; r < task_map_pkg::grid_dim; r++) begin
      for (int c = 0; c < task_map_pkg::grid_dim; c++) begin
        busy_map[r][c] = (cnt[r][c] != '0);
      end
    end
  end

endmodule

/* logic/pe_select.sv */
// ####################
// PE selector
// Ranks free PEs by distance and idle neighbours, picks one per request
// ####################

`timescale 1ns/1ps

module pe_select (
  input  logic                 clk,
  input  logic                 rst_b,
  task_req_if.dst              req,
  input  logic [task_map_pkg::grid_dim-1:0][task_map_pkg::grid_dim-1:0] busy_map,
  output logic                 alloc,
  output task_map_pkg::coord_t alloc_x,
  output task_map_pkg::coord_t alloc_y,
  map_result_if.src            res
);

  logic [task_map_pkg::grid_dim-1:0][task_map_pkg::grid_dim-1:0] free_map;
  task_map_pkg::dist_t  cand_dist [task_map_pkg::grid_dim][task_map_pkg::grid_dim];
  task_map_pkg::count_t idle_cnt [task_map_pkg::grid_dim][task_map_pkg::grid_dim];

  task_map_pkg::coord_t last_x;
  task_map_pkg::coord_t last_y;
  task_map_pkg::coord_t ref_x;
  task_map_pkg::coord_t ref_y;

  logic                 found;
  task_map_pkg::coord_t best_x;
  task_map_pkg::coord_t best_y;
  task_map_pkg::dist_t  best_dist;
  task_map_pkg::count_t best_cnt;

  // Manhattan distance between two tiles
  function automatic task_map_pkg::dist_t grid_dist(
    input task_map_pkg::coord_t r0,
    input task_map_pkg::coord_t c0,
    input task_map_pkg::coord_t r1,
    input task_map_pkg::coord_t c1
  );
    task_map_pkg::dist_t dr;
    task_map_pkg::dist_t dc;
    dr = (r0 > r1) ? task_map_pkg::dist_t'(r0 - r1) : task_map_pkg::dist_t'(r1 - r0);
    dc = (c0 > c1) ? task_map_pkg::dist_t'(c0 - c1) : task_map_pkg::dist_t'(c1 - c0);
    return dr + dc;
  endfunction

  // ####################
  // Cost matrices
  // ####################

  // Controller tile is reserved and never counts as free
  always_comb begin
    for (int r = 0; r < task_map_pkg::grid_dim; r++) begin
      for (int c = 0; c < task_map_pkg::grid_dim; c++) begin
        free_map[r][c] = !busy_map[r][c] &&
                         !(task_map_pkg::coord_t'(r) == task_map_pkg::ctrl_row &&
                           task_map_pkg::coord_t'(c) == task_map_pkg::ctrl_col);
      end
    end
  end

  // Root tasks measure from the controller, child tasks from the last PE
  assign ref_x = req.root ? task_map_pkg::ctrl_row : last_x;
  assign ref_y = req.root ? task_map_pkg::ctrl_col : last_y;

  always_comb begin
    for (int r = 0; r < task_map_pkg::grid_dim; r++) begin
      for (int c = 0; c < task_map_pkg::grid_dim; c++) begin
        cand_dist[r][c] = grid_dist(task_map_pkg::coord_t'(r), task_map_pkg::coord_t'(c),
                                    ref_x, ref_y);
      end
    end
  end

  // Idle neighbours within opt_dist of each tile
  always_comb begin
    for (int r = 0; r < task_map_pkg::grid_dim; r++) begin
      for (int c = 0; c < task_map_pkg::grid_dim; c++) begin
        idle_cnt[r][c] = '0;
        for (int i = 0; i < task_map_pkg::grid_dim; i++) begin
          for (int j = 0; j < task_map_pkg::grid_dim; j++) begin
            if (free_map[i][j] &&
                grid_dist(task_map_pkg::coord_t'(r), task_map_pkg::coord_t'(c),
                          task_map_pkg::coord_t'(i), task_map_pkg::coord_t'(j)) != '0 &&
                grid_dist(task_map_pkg::coord_t'(r), task_map_pkg::coord_t'(c),
                          task_map_pkg::coord_t'(i), task_map_pkg::coord_t'(j))
                <= task_map_pkg::opt_dist) begin
              idle_cnt[r][c] = idle_cnt[r][c] + task_map_pkg::count_t'(1);
            end
          end
        end
      end
    end
  end

  // ####################
  // Ranking
  // ####################

  // Scan in id order so a remaining tie keeps the lowest id
  always_comb begin
    found     = 1'b0;
    best_x    = '0;
    best_y    = '0;
    best_dist = '1;
    best_cnt  = '0;
    for (int r = 0; r < task_map_pkg::grid_dim; r++) begin
      for (int c = 0; c < task_map_pkg::grid_dim; c++) begin
        if (free_map[r][c] &&
            (!found || cand_dist[r][c] < best_dist ||
             (req.root && cand_dist[r][c] == best_dist && idle_cnt[r][c] > best_cnt))) begin
          found     = 1'b1;
          best_x    = task_map_pkg::coord_t'(r);
          best_y    = task_map_pkg::coord_t'(c);
          best_dist = cand_dist[r][c];
          best_cnt  = idle_cnt[r][c];
        end
      end
    end
  end

  assign alloc   = req.valid && found;
  assign alloc_x = best_x;
  assign alloc_y = best_y;

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      res.valid   <= 1'b0;
      res.busy    <= 1'b0;
      res.app_end <= 1'b0;
      last_x      <= task_map_pkg::ctrl_row;
      last_y      <= task_map_pkg::ctrl_col;
    end else begin
      res.valid   <= req.valid && found;
      res.busy    <= req.valid && !found;
      res.app_end <= req.app_end;
      if (alloc) begin
        last_x <= best_x;
        last_y <= best_y;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req.valid) begin
      res.x    <= best_x;
      res.y    <= best_y;
      res.root <= req.root;
      res.row  <= req.row;
      res.col  <= req.col;
    end
  end

endmodule

/* logic/task_id_map.sv */
// ####################
// Task id table
// Records placed ids per task-graph cell, drives src_id and dest_id
// ####################

`timescale 1ns/1ps

module task_id_map (
  input  logic                  clk,
  input  logic                  rst_b,
  map_result_if.dst             res,
  output logic                  map_valid,
  output logic                  map_busy,
  output task_map_pkg::pe_id_t  src_id,
  output task_map_pkg::pe_id_t  dest_id
);

  task_map_pkg::pe_id_t id_tab [task_map_pkg::grid_dim][task_map_pkg::grid_dim];
  logic [task_map_pkg::grid_dim-1:0][task_map_pkg::grid_dim-1:0] id_ok;

  task_map_pkg::pe_id_t src_next;
  task_map_pkg::pe_id_t dest_next;

  // Child tasks point at the transposed cell when it holds an id
  // A flush in the same cycle hides the old entry
  always_comb begin
    src_next = task_map_pkg::pe_id(res.x, res.y);
    if (!res.root && id_ok[res.col][res.row] && !res.app_end) begin
      dest_next = id_tab[res.col][res.row];
    end else begin
      dest_next = src_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      map_valid <= 1'b0;
      map_busy  <= 1'b0;
      src_id    <= '0;
      dest_id   <= '0;
      id_ok     <= '0;
    end else begin
      map_valid <= res.valid;
      map_busy  <= res.busy;
      if (res.valid) begin
        src_id  <= src_next;
        dest_id <= dest_next;
      end
      // Flush first, then record the current placement
      if (res.app_end) begin
        id_ok <= '0;
      end
      if (res.valid) begin
        id_ok[res.row][res.col] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (res.valid) begin
      id_tab[res.row][res.col] <= src_next;
    end
  end

endmodule

/* logic/task_mapper.sv */
// ####################
// Task mapper top
// Capture, PE selection, occupancy and id table for one 4x4 cluster
// ####################

`timescale 1ns/1ps

module task_mapper #(
  parameter int hold_cycles = 20
) (
  input  logic                 clk,
  input  logic                 rst_b,
  input  logic                 task_req,
  input  logic                 root,
  input  task_map_pkg::coord_t row,
  input  task_map_pkg::coord_t col,
  input  logic                 app_end,
  output logic                 map_valid,
  output logic                 map_busy,
  output task_map_pkg::pe_id_t src_id,
  output task_map_pkg::pe_id_t dest_id
);

  task_req_if   req_bus ();
  map_result_if res_bus ();

  logic                 alloc;
  task_map_pkg::coord_t alloc_x;
  task_map_pkg::coord_t alloc_y;
  logic [task_map_pkg::grid_dim-1:0][task_map_pkg::grid_dim-1:0] busy_map;

  task_req_capture u_capture (
    .clk     (clk),
    .rst_b   (rst_b),
    .task_req(task_req),
    .root    (root),
    .row     (row),
    .col     (col),
    .app_end (app_end),
    .req     (req_bus.src)
  );

  pe_select u_select (
    .clk     (clk),
    .rst_b   (rst_b),
    .req     (req_bus.dst),
    .busy_map(busy_map),
    .alloc   (alloc),
    .alloc_x (alloc_x),
    .alloc_y (alloc_y),
    .res     (res_bus.src)
  );

  pe_occupancy #(
    .hold_cycles(hold_cycles)
  ) u_occupancy (
    .clk     (clk),
    .rst_b   (rst_b),
    .alloc   (alloc),
    .alloc_x (alloc_x),
    .alloc_y (alloc_y),
    .busy_map(busy_map)
  );

  task_id_map u_id_map (
    .clk      (clk),
    .rst_b    (rst_b),
    .res      (res_bus.dst),
    .map_valid(map_valid),
    .map_busy (map_busy),
    .src_id   (src_id),
    .dest_id  (dest_id)
  );

endmodule

/* tests/task_mapper_properties.sv */
// ####################
// Task mapper properties
// Concurrent checks on the top-level result pulses
// ####################

`timescale 1ns/1ps

module task_mapper_properties (
  input logic                 clk,
  input logic                 rst_b,
  input logic                 task_req,
  input logic                 map_valid,
  input logic                 map_busy,
  input task_map_pkg::pe_id_t src_id
);

  localparam task_map_pkg::pe_id_t ctrl_id =
    task_map_pkg::pe_id(task_map_pkg::ctrl_row, task_map_pkg::ctrl_col);

  // Failed assertion count
  int fail_count = 0;

  one_kind: assert property (@(posedge clk) disable iff (!rst_b)
    !(map_valid && map_busy))
    else begin
      $error("map_valid and map_busy are high together");
      fail_count++;
    end

  reset_low: assert property (@(posedge clk)
    !rst_b |=> (!map_valid && !map_busy))
    else begin
      $error("result pulse right after reset");
      fail_count++;
    end

  // Output edge is two edges after capture
  req_to_result: assert property (@(posedge clk) disable iff (!rst_b)
    task_req |-> ##3 (map_valid || map_busy))
    else begin
      $error("request produced no result two cycles later");
      fail_count++;
    end

  result_from_req: assert property (@(posedge clk) disable iff (!rst_b)
    (map_valid || map_busy) |-> $past(task_req, 3))
    else begin
      $error("result pulse without a request two cycles earlier");
      fail_count++;
    end

  no_ctrl_tile: assert property (@(posedge clk) disable iff (!rst_b)
    map_valid |-> src_id != ctrl_id)
    else begin
      $error("controller tile was mapped");
      fail_count++;
    end

endmodule

bind task_mapper task_mapper_properties props (
  .clk      (clk),
  .rst_b    (rst_b),
  .task_req (task_req),
  .map_valid(map_valid),
  .map_busy (map_busy),
  .src_id   (src_id)
);

/* tests/tb_task_mapper.sv */
// ####################
// Task mapper testbench
// Directed and random requests checked against a reference model
// ####################

`timescale 1ns/1ps

module tb_task_mapper;

  localparam int hold_cycles = 20;
  localparam int n_random = 200;
  localparam int dim = task_map_pkg::grid_dim;
  // Cycles of all tests plus a margin
  localparam int run_cycles = 3 + 40 + 2 * (hold_cycles + 30) + n_random * 5 + 200;

  logic                 clk;
  logic                 rst_b;
  logic                 task_req;
  logic                 root;
  task_map_pkg::coord_t row;
  task_map_pkg::coord_t col;
  logic                 app_end;
  logic                 map_valid;
  logic                 map_busy;
  task_map_pkg::pe_id_t src_id;
  task_map_pkg::pe_id_t dest_id;

  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          busy_seen = 0;
  logic [31:0] rng = 32'h44ddef2d;
  string       test_name = "reset";

  // Model state of release edges, last position and id table
  int   free_edge [dim][dim];
  int   last_r;
  int   last_c;
  logic tab_ok [dim][dim];
  int   tab_id [dim][dim];

  // Expected results in request order
  int          exp_edge_q [$];
  logic [10:0] exp_q [$];
  string       exp_name_q [$];

  task_mapper #(
    .hold_cycles(hold_cycles)
  ) dut (
    .clk      (clk),
    .rst_b    (rst_b),
    .task_req (task_req),
    .root     (root),
    .row      (row),
    .col      (col),
    .app_end  (app_end),
    .map_valid(map_valid),
    .map_busy (map_busy),
    .src_id   (src_id),
    .dest_id  (dest_id)
  );

  // Edge count moves before the rising edge
  initial begin
    clk = 1'b0;
    forever begin
      #2;
      cyc = cyc + 1;
      clk = 1'b1;
      #2;
      clk = 1'b0;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int abs_diff(input int a, input int b);
    return (a > b) ? a - b : b - a;
  endfunction

  function automatic void flush_table();
    for (int i = 0; i < dim; i++) begin
      for (int j = 0; j < dim; j++) begin
        tab_ok[i][j] = 1'b0;
      end
    end
  endfunction

  // ####################
  // Reference model
  // ####################

  // Predicts one request selected at edge sel as {busy, src_id, dest_id}
  function automatic logic [10:0] predict(input logic is_root, input int r, input int c,
                                          input logic flush, input int sel);
    logic                 fr [dim][dim];
    int                   ref_r;
    int                   ref_c;
    int                   best;
    int                   key;
    int                   n;
    int                   pick_r;
    int                   pick_c;
    task_map_pkg::pe_id_t src;
    task_map_pkg::pe_id_t dest;
    for (int i = 0; i < dim; i++) begin
      for (int j = 0; j < dim; j++) begin
        fr[i][j] = !(i == task_map_pkg::ctrl_row && j == task_map_pkg::ctrl_col) &&
                   sel >= free_edge[i][j];
      end
    end
    ref_r = is_root ? int'(task_map_pkg::ctrl_row) : last_r;
    ref_c = is_root ? int'(task_map_pkg::ctrl_col) : last_c;
    best = -1;
    pick_r = 0;
    pick_c = 0;
    // Smaller key wins
    // Row-major order keeps the lowest id on a tie
    for (int i = 0; i < dim; i++) begin
      for (int j = 0; j < dim; j++) begin
        if (fr[i][j]) begin
          n = 0;
          for (int p = 0; p < dim; p++) begin
            for (int q = 0; q < dim; q++) begin
              if (fr[p][q] && abs_diff(i, p) + abs_diff(j, q) >= 1 &&
                  abs_diff(i, p) + abs_diff(j, q) <= task_map_pkg::opt_dist) begin
                n++;
              end
            end
          end
          key = (abs_diff(i, ref_r) + abs_diff(j, ref_c)) * 32 + (is_root ? 16 - n : 0);
          if (best < 0 || key < best) begin
            best = key;
            pick_r = i;
            pick_c = j;
          end
        end
      end
    end
    if (flush) begin
      flush_table();
    end
    if (best < 0) begin
      return {1'b1, 10'd0};
    end
    free_edge[pick_r][pick_c] = sel + hold_cycles + 1;
    last_r = pick_r;
    last_c = pick_c;
    src = task_map_pkg::pe_id_t'(pick_r * task_map_pkg::id_row_stride + pick_c);
    dest = (!is_root && tab_ok[c][r]) ? task_map_pkg::pe_id_t'(tab_id[c][r]) : src;
    tab_ok[r][c] = 1'b1;
    tab_id[r][c] = src;
    return {1'b0, src, dest};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      $display("Error %s expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  // ####################
  // Stimulus tasks
  // ####################

  task automatic issue(input logic is_root, input int r, input int c, input logic flush);
    @(posedge clk);
    task_req <= 1'b1;
    root     <= is_root;
    row      <= task_map_pkg::coord_t'(r);
    col      <= task_map_pkg::coord_t'(c);
    app_end  <= flush;
    exp_q.push_back(predict(is_root, r, c, flush, cyc + 2));
    exp_edge_q.push_back(cyc + 3);
    exp_name_q.push_back(test_name);
  endtask

  task automatic quiet(input int n);
    repeat (n) begin
      @(posedge clk);
      task_req <= 1'b0;
      app_end  <= 1'b0;
    end
  endtask

  task automatic end_app();
    @(posedge clk);
    task_req <= 1'b0;
    app_end  <= 1'b1;
    flush_table();
  endtask

  task automatic drain();
    quiet(1);
    while (exp_edge_q.size() != 0) begin
      quiet(1);
    end
    @(negedge clk);
  endtask

  // Compare each result at the falling edge after its output edge
  initial begin
    logic [10:0] e;
    string       name;
    forever begin
      @(negedge clk);
      if (exp_edge_q.size() != 0 && exp_edge_q[0] == cyc) begin
        e = exp_q.pop_front();
        name = exp_name_q.pop_front();
        exp_edge_q.delete(0);
        check_value({name, " map_busy"}, e[10], map_busy);
        check_value({name, " map_valid"}, !e[10], map_valid);
        if (map_busy === 1'b1) begin
          busy_seen++;
        end
        if (!e[10]) begin
          check_value({name, " src_id"}, e[9:5], src_id);
          check_value({name, " dest_id"}, e[4:0], dest_id);
        end
      end else if (rst_b) begin
        assert (map_valid === 1'b0 && map_busy === 1'b0) else begin
          $display("Result pulse at cycle %0d with no request pending", cyc);
          errors++;
        end
      end
    end
  end

  initial begin
    repeat (run_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, the stimulus did not finish", run_cycles);
    $display("tests failed");
    $finish;
  end

  // ####################
  // Tests
  // ####################

  initial begin
    int id21;
    int n;
    rst_b    = 1'b0;
    task_req = 1'b0;
    root     = 1'b0;
    row      = '0;
    col      = '0;
    app_end  = 1'b0;
    for (int i = 0; i < dim; i++) begin
      for (int j = 0; j < dim; j++) begin
        free_edge[i][j] = 0;
      end
    end
    flush_table();
    last_r = task_map_pkg::ctrl_row;
    last_c = task_map_pkg::ctrl_col;
    repeat (3) @(posedge clk);
    rst_b <= 1'b1;
    @(negedge clk);
    check_value("reset map_valid", 0, map_valid);
    check_value("reset map_busy", 0, map_busy);
    check_value("reset src_id", 0, src_id);
    check_value("reset dest_id", 0, dest_id);

    // Ties with id 26 on distance and idle neighbours
    test_name = "root_empty";
    issue(1'b1, 0, 0, 1'b0);
    drain();
    check_value("root_empty src_id", 19, src_id);
    check_value("root_empty dest_id", 19, dest_id);

    test_name = "child_chain";
    for (int i = 0; i < 6; i++) begin
      issue(1'b0, 0, i % dim, 1'b0);
    end
    drain();

    test_name = "transpose";
    issue(1'b0, 2, 1, 1'b0);
    drain();
    id21 = tab_id[2][1];
    issue(1'b0, 1, 2, 1'b0);
    drain();
    check_value("transpose dest_id", id21, dest_id);
    end_app();
    issue(1'b0, 1, 2, 1'b0);
    drain();
    check_value("flush dest_id", tab_id[1][2], dest_id);

    test_name = "exhaust";
    quiet(hold_cycles + 5);
    n = busy_seen;
    for (int i = 0; i < 16; i++) begin
      issue(1'b1, i / dim, i % dim, 1'b0);
    end
    drain();
    check_value("exhaust busy count", n + 1, busy_seen);
    quiet(hold_cycles + 5);
    issue(1'b1, 0, 0, 1'b0);
    drain();
    check_value("release busy count", n + 1, busy_seen);

    test_name = "random";
    for (int i = 0; i < n_random; i++) begin
      rng = xorshift(rng);
      if (rng[7:4] == 4'hf) begin
        end_app();
      end
      issue(rng[1:0] == 2'b00, rng[9:8], rng[11:10], rng[15:12] == 4'h0);
      if (rng[17:16] != 2'b00) begin
        quiet(rng[17:16]);
      end
    end
    drain();

    assert (exp_edge_q.size() == 0) else begin
      $display("Results still missing for %0d requests", exp_edge_q.size());
      errors++;
    end
    errors = errors + dut.props.fail_count;
    $display("Errors %0d over %0d checks", errors, checks);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* tb.f */
logic/task_map_pkg.sv
logic/task_req_if.sv
logic/map_result_if.sv
logic/task_req_capture.sv
logic/pe_occupancy.sv
logic/pe_select.sv
logic/task_id_map.sv
logic/task_mapper.sv
tests/task_mapper_properties.sv
tests/tb_task_mapper.sv

/* Bender.yml */
package:
  name: task_mapper

sources:
  - logic/task_map_pkg.sv
  - logic/task_req_if.sv
  - logic/map_result_if.sv
  - logic/task_req_capture.sv
  - logic/pe_occupancy.sv
  - logic/pe_select.sv
  - logic/task_id_map.sv
  - logic/task_mapper.sv
  - target: test
    files:
      - tests/task_mapper_properties.sv
      - tests/tb_task_mapper.sv
